// ==== design/branchPredPkg.sv ====
// Shared widths, opcode constants and stage bundles for the branch front end
// Only conditional B-type branches are predicted; JAL and JALR are not handled
package branchPredPkg;

    // Plain vector types
    typedef logic [31:0] pcT;
    typedef logic [31:0] instrT;
    typedef logic [31:0] offsetT;
    typedef logic [2:0]  funct3T;
    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] regDataT;
    typedef logic [5:0]  btbIndexT;
    typedef logic [23:0] btbTagT;
    typedef logic [15:0] countT;

    // Buffer geometry, index is pc[7:2] and tag is pc[31:8]
    localparam int btbIndexBits = 6;
    localparam int btbTagBits   = 24;
    localparam int btbEntries   = 1 << btbIndexBits;

    localparam pcT resetPc = 32'h0000_0000;
    localparam logic [6:0] opcodeBranch = 7'b1100011;

    // Branch condition codes
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

    // Saturation point of the statistics counters
    localparam countT countMax = '1;

    // Captured by the decode register
    typedef struct packed {
        logic  valid;
        pcT    pc;
        instrT instr;
        logic  predTaken;
    } fetchToDecodeT;

    // Captured by the execute register
    typedef struct packed {
        logic    valid;
        pcT      pc;
        funct3T  funct3;
        offsetT  offset;
        logic    predTaken;
        regDataT rs1Data;
        regDataT rs2Data;
    } decodeToExecuteT;

    // Outcome of one resolved branch
    typedef struct packed {
        logic valid;
        pcT   pc;
        logic taken;
        pcT   target;
        logic predTaken;
        logic mispredict;
    } resolveT;

endpackage

// ==== design/branchTargetBuffer.sv ====
// Direct-mapped, no valid bits; reset tags are all ones
// A pc with bits 31:8 all ones can hit an entry that was never written
`timescale 1ns/1ps

module branchTargetBuffer (
    input  logic                  clk,
    input  logic                  reset,
    input  branchPredPkg::pcT     pcF,
    input  logic                  btbWrite,
    input  branchPredPkg::pcT     btbWritePc,
    input  branchPredPkg::offsetT btbWriteOffset,
    output logic                  btbHit,
    output branchPredPkg::offsetT btbOffset
);
    import branchPredPkg::*;

    // Tag and offset arrays, kept apart so only tags take reset
    btbTagT   tagMem    [btbEntries];
    offsetT   offsetMem [btbEntries];

    btbIndexT lookupIndex;
    btbTagT   lookupTag;
    btbIndexT writeIndex;
    btbTagT   writeTag;

    // Word-aligned pc, low two bits ignored
    assign lookupIndex = pcF[btbIndexBits+1:2];
    assign lookupTag   = pcF[btbTagBits+btbIndexBits+1:btbIndexBits+2];

    assign writeIndex  = btbWritePc[btbIndexBits+1:2];
    assign writeTag    = btbWritePc[btbTagBits+btbIndexBits+1:btbIndexBits+2];

    // Fetch lookup in the same cycle
    assign btbHit    = (tagMem[lookupIndex] == lookupTag);
    assign btbOffset = offsetMem[lookupIndex];

    // Tag store
    // A write here is seen by lookups from the next cycle on
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < btbEntries; i++) begin
                tagMem[i] <= '1;
            end
        end else if (btbWrite) begin
            tagMem[writeIndex] <= writeTag;
        end
    end

    // Offset store
    always_ff @(posedge clk) begin
        if (btbWrite) begin
            offsetMem[writeIndex] <= btbWriteOffset;
        end
    end

endmodule

// ==== design/fetchPc.sv ====
// Holds the fetch address; the instruction word comes back in the same cycle
// Redirect from execute wins over any prediction
`timescale 1ns/1ps

module fetchPc (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         btbHit,
    input  branchPredPkg::offsetT        btbOffset,
    input  logic                         redirect,
    input  branchPredPkg::pcT            redirectPc,
    input  branchPredPkg::instrT         instrF,
    output branchPredPkg::pcT            pcF,
    output branchPredPkg::fetchToDecodeT fetchBundle
);
    import branchPredPkg::*;

    pcT pcNext;
    pcT pcSeq;
    pcT pcPred;

    // Candidate addresses
    assign pcSeq  = pcF + pcT'(4);
    assign pcPred = pcF + btbOffset;

    // Priority: redirect, then predicted taken, then sequential
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end else if (btbHit) begin
            pcNext = pcPred;
        end else begin
            pcNext = pcSeq;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pcF <= resetPc;
        end else begin
            pcF <= pcNext;
        end
    end

    // Fetch always produces a word
    // wrong-path words are squashed by the decode flush
    always_comb begin
        fetchBundle.valid     = 1'b1;
        fetchBundle.pc        = pcF;
        fetchBundle.instr     = instrF;
        fetchBundle.predTaken = btbHit;
    end

endmodule

// ==== design/branchDecode.sv ====
// Decode stage, only B-type branches leave with valid set
// Register values are returned by the outside in the same cycle as the addresses
`timescale 1ns/1ps

module branchDecode (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  branchPredPkg::fetchToDecodeT   fetchBundle,
    input  branchPredPkg::regDataT         rs1Data,
    input  branchPredPkg::regDataT         rs2Data,
    output branchPredPkg::regAddrT         rs1Addr,
    output branchPredPkg::regAddrT         rs2Addr,
    output branchPredPkg::decodeToExecuteT decodeBundle
);
    import branchPredPkg::*;

    fetchToDecodeT fetchQ;
    instrT         instrD;
    logic          isBranch;
    offsetT        branchOffset;

    // Decode pipeline register
    // Flush drops the word fetched on the mispredicted path
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fetchQ <= '0;
        end else if (flush) begin
            fetchQ.valid <= 1'b0;
        end else begin
            fetchQ <= fetchBundle;
        end
    end

    assign instrD = fetchQ.instr;

    // Opcode check
    assign isBranch = (instrD[6:0] == opcodeBranch);

    // B-type immediate: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    // Bit 0 is always zero, sign taken from bit 31
    assign branchOffset = {
        {19{instrD[31]}},
        instrD[31],
        instrD[7],
        instrD[30:25],
        instrD[11:8],
        1'b0
    };

    // Source register fields
    assign rs1Addr = instrD[19:15];
    assign rs2Addr = instrD[24:20];

    // Bundle for execute
    always_comb begin
        decodeBundle.valid     = fetchQ.valid && isBranch;
        decodeBundle.pc        = fetchQ.pc;
        decodeBundle.funct3    = instrD[14:12];
        decodeBundle.offset    = branchOffset;
        decodeBundle.predTaken = fetchQ.predTaken;
        decodeBundle.rs1Data   = rs1Data;
        decodeBundle.rs2Data   = rs2Data;
    end

endmodule

// ==== design/branchExecute.sv ====
// Branch resolution, redirect and buffer allocation
// Allocation only for taken branches that missed, entries are never cleared
`timescale 1ns/1ps

module branchExecute (
    input  logic                           clk,
    input  logic                           reset,
    input  branchPredPkg::decodeToExecuteT decodeBundle,
    output branchPredPkg::resolveT         resolve,
    output logic                           redirect,
    output branchPredPkg::pcT              redirectPc,
    output logic                           flush,
    output logic                           btbWrite,
    output branchPredPkg::pcT              btbWritePc,
    output branchPredPkg::offsetT          btbWriteOffset
);
    import branchPredPkg::*;

    decodeToExecuteT execQ;
    logic            taken;
    logic            mispredict;
    pcT              correctPc;

    // Execute pipeline register
    // A mispredict here also squashes the bundle arriving from decode
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            execQ <= '0;
        end else if (flush) begin
            execQ.valid <= 1'b0;
        end else begin
            execQ <= decodeBundle;
        end
    end

    // Condition evaluation
    always_comb begin
        case (execQ.funct3)
            f3Beq:   taken = (execQ.rs1Data == execQ.rs2Data);
            f3Bne:   taken = (execQ.rs1Data != execQ.rs2Data);
            f3Blt:   taken = ($signed(execQ.rs1Data) < $signed(execQ.rs2Data));
            f3Bge:   taken = ($signed(execQ.rs1Data) >= $signed(execQ.rs2Data));
            f3Bltu:  taken = (execQ.rs1Data < execQ.rs2Data);
            f3Bgeu:  taken = (execQ.rs1Data >= execQ.rs2Data);
            // Undefined codes fall through
            default: taken = 1'b0;
        endcase
    end

    // Architecturally correct next address
    assign correctPc = taken ? (execQ.pc + execQ.offset) : (execQ.pc + pcT'(4));

    // Prediction wrong in direction
    // target is always right on a hit since the full address is tagged
    assign mispredict = execQ.valid && (taken != execQ.predTaken);

    // Redirect fetch and squash decode on the same edge
    assign redirect   = mispredict;
    assign flush      = mispredict;
    assign redirectPc = correctPc;

    // Allocate on taken branches that missed
    assign btbWrite       = execQ.valid && taken && !execQ.predTaken;
    assign btbWritePc     = execQ.pc;
    assign btbWriteOffset = execQ.offset;

    // Outcome for stats and the top level
    always_comb begin
        resolve.valid      = execQ.valid;
        resolve.pc         = execQ.pc;
        resolve.taken      = taken;
        resolve.target     = correctPc;
        resolve.predTaken  = execQ.predTaken;
        resolve.mispredict = mispredict;
    end

endmodule

// ==== design/predictionStats.sv ====
// Resolved branch and mispredict counters, both saturate at all ones
`timescale 1ns/1ps

module predictionStats (
    input  logic                   clk,
    input  logic                   reset,
    input  branchPredPkg::resolveT resolve,
    output branchPredPkg::countT   branchCount,
    output branchPredPkg::countT   mispredictCount
);
    import branchPredPkg::*;

    logic branchStep;
    logic mispredictStep;

    // Step only below the ceiling
    assign branchStep     = resolve.valid && (branchCount != countMax);
    assign mispredictStep = resolve.valid && resolve.mispredict
                            && (mispredictCount != countMax);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            branchCount     <= '0;
            mispredictCount <= '0;
        end else begin
            if (branchStep) begin
                branchCount <= branchCount + countT'(1);
            end
            // Mispredicts counted independently
            if (mispredictStep) begin
                mispredictCount <= mispredictCount + countT'(1);
            end
        end
    end

endmodule

// ==== design/branchFrontEnd.sv ====
// Fetch, decode and execute branch front end, no stalls
// Instruction words and register values are supplied by the caller combinationally
`timescale 1ns/1ps

module branchFrontEnd (
    input  logic                   clk,
    input  logic                   reset,
    input  branchPredPkg::instrT   instrF,
    input  branchPredPkg::regDataT rs1Data,
    input  branchPredPkg::regDataT rs2Data,
    output branchPredPkg::pcT      pcF,
    output branchPredPkg::regAddrT rs1Addr,
    output branchPredPkg::regAddrT rs2Addr,
    output branchPredPkg::resolveT resolve,
    output branchPredPkg::countT   branchCount,
    output branchPredPkg::countT   mispredictCount
);
    import branchPredPkg::*;

    // Buffer lookup
    logic            btbHit;
    offsetT          btbOffset;

    // Execute back to fetch, decode and buffer
    logic            redirect;
    pcT              redirectPc;
    logic            flush;
    logic            btbWrite;
    pcT              btbWritePc;
    offsetT          btbWriteOffset;

    // Stage bundles
    fetchToDecodeT   fetchBundle;
    decodeToExecuteT decodeBundle;

    fetchPc fetchStage (
        .clk         (clk),
        .reset       (reset),
        .btbHit      (btbHit),
        .btbOffset   (btbOffset),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .instrF      (instrF),
        .pcF         (pcF),
        .fetchBundle (fetchBundle)
    );

    branchTargetBuffer btb (
        .clk            (clk),
        .reset          (reset),
        .pcF            (pcF),
        .btbWrite       (btbWrite),
        .btbWritePc     (btbWritePc),
        .btbWriteOffset (btbWriteOffset),
        .btbHit         (btbHit),
        .btbOffset      (btbOffset)
    );

    branchDecode decodeStage (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .fetchBundle  (fetchBundle),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .rs1Addr      (rs1Addr),
        .rs2Addr      (rs2Addr),
        .decodeBundle (decodeBundle)
    );

    branchExecute executeStage (
        .clk            (clk),
        .reset          (reset),
        .decodeBundle   (decodeBundle),
        .resolve        (resolve),
        .redirect       (redirect),
        .redirectPc     (redirectPc),
        .flush          (flush),
        .btbWrite       (btbWrite),
        .btbWritePc     (btbWritePc),
        .btbWriteOffset (btbWriteOffset)
    );

    predictionStats stats (
        .clk             (clk),
        .reset           (reset),
        .resolve         (resolve),
        .branchCount     (branchCount),
        .mispredictCount (mispredictCount)
    );

endmodule

// ==== bench/branchRefModel.svh ====
// Program image, register values and architectural reference for the front end testbench
// Included in the testbench module body after the package import
`ifndef BRANCH_REF_MODEL_SVH
`define BRANCH_REF_MODEL_SVH

localparam int         imageWords = 256;
localparam logic [6:0] brOpcode   = 7'b1100011;

logic [31:0] lfsrState;
instrT       image [imageWords];
logic        isBr  [imageWords];
funct3T      brF3  [imageWords];
offsetT      brOff [imageWords];
regAddrT     brRs1 [imageWords];
regAddrT     brRs2 [imageWords];
regDataT     regVal [32];

// Model buffer keeps the full branch address per entry, all ones after reset
pcT modelAddr [64];
pcT walkPc;
int branchTally;
int mispredictTally;
bit takenSeen    [8];
bit notTakenSeen [8];

// Fibonacci LFSR with taps 32 22 2 1, one step per returned bit
function automatic logic [31:0] randBits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int b = 0; b < n; b++) begin
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        bits      = {bits[30:0], fb};
    end
    return bits;
endfunction

// Branch direction under the RISC-V rules
function automatic logic branchCond(input funct3T f3, input regDataT a, input regDataT b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// B-type word from a byte offset
function automatic instrT encodeBranch(input logic [12:0] imm, input regAddrT r1,
                                       input regAddrT r2, input funct3T f3);
    return {imm[12], imm[10:5], r2, r1, f3, imm[4:1], imm[11], brOpcode};
endfunction

// One branch every 2 to 5 words with fillers up to the taken target
// so both directions reach every later branch word
task automatic buildImage();
    int      i;
    int      k;
    logic    want;
    logic    found;
    regAddrT r1;
    regAddrT r2;
    regAddrT cand;
    funct3T  f3;
    bit      lastDir [8];
    lfsrState = 32'h64b56996;
    for (int r = 0; r < 32; r++) begin
        regVal[r] = randBits(32);
    end
    i = 0;
    while (i < imageWords - 1) begin
        k  = 2 + randBits(2);
        f3 = funct3T'(randBits(3));
        r1 = regAddrT'(randBits(5));
        r2 = regAddrT'(randBits(5));
        if (i + k > imageWords - 1) begin
            k = imageWords - 1 - i;
        end
        // Second operand picked so each code alternates its direction
        want  = !lastDir[f3];
        found = 1'b0;
        for (int j = 0; j < 32 && !found; j++) begin
            cand = r2 + regAddrT'(j);
            if (branchCond(f3, regVal[r1], regVal[cand]) == want) begin
                r2    = cand;
                found = 1'b1;
            end
        end
        lastDir[f3] = branchCond(f3, regVal[r1], regVal[r2]);
        isBr[i]  = 1'b1;
        brF3[i]  = f3;
        brOff[i] = offsetT'(4 * k);
        brRs1[i] = r1;
        brRs2[i] = r2;
        image[i] = encodeBranch(brOff[i][12:0], r1, r2, f3);
        // Fillers never carry the branch opcode
        for (int w = i + 1; w < i + k; w++) begin
            image[w] = randBits(32);
            if (image[w][6:0] == brOpcode) begin
                image[w][2] = 1'b1;
            end
            isBr[w] = 1'b0;
        end
        i = i + k;
    end
    // Always-taken BEQ x0, x0 back to word 0 closes the loop
    isBr[imageWords-1]  = 1'b1;
    brF3[imageWords-1]  = 3'b000;
    brOff[imageWords-1] = -offsetT'(4 * (imageWords - 1));
    brRs1[imageWords-1] = '0;
    brRs2[imageWords-1] = '0;
    image[imageWords-1] = encodeBranch(brOff[imageWords-1][12:0], '0, '0, 3'b000);
    // Model state after reset
    for (int e = 0; e < 64; e++) begin
        modelAddr[e] = '1;
    end
    walkPc          = 32'h0;
    branchTally     = 0;
    mispredictTally = 0;
endtask

// Next branch on the architectural path, buffer updated on resolution
task automatic walkToBranch(output pcT pc, output logic taken, output pcT target,
                            output logic pred);
    int w;
    while (!isBr[walkPc[9:2]]) begin
        walkPc = walkPc + 32'd4;
    end
    w      = walkPc[9:2];
    pc     = walkPc;
    taken  = branchCond(brF3[w], regVal[brRs1[w]], regVal[brRs2[w]]);
    target = taken ? walkPc + brOff[w] : walkPc + 32'd4;
    pred   = (modelAddr[walkPc[7:2]] == walkPc);
    // Allocate only taken branches that missed
    if (taken && !pred) begin
        modelAddr[walkPc[7:2]] = walkPc;
    end
    branchTally++;
    if (taken != pred) begin
        mispredictTally++;
    end
    if (taken) begin
        takenSeen[brF3[w]] = 1'b1;
    end else begin
        notTakenSeen[brF3[w]] = 1'b1;
    end
    walkPc = target;
endtask

`endif

// ==== bench/branchFrontEndTb.sv ====
// Random 256-word image looped from word 255, fixed register file
// Run ends after a fixed number of resolved branches
`timescale 1ns/1ps

module branchFrontEndTb;
    import branchPredPkg::*;

    localparam int clkPeriod     = 10;
    localparam int numResolves   = 300;
    localparam int plannedCycles = numResolves * 6 + 8;

    logic    clk;
    logic    reset;
    instrT   instrF;
    regDataT rs1Data;
    regDataT rs2Data;
    pcT      pcF;
    regAddrT rs1Addr;
    regAddrT rs2Addr;
    resolveT resolve;
    countT   branchCount;
    countT   mispredictCount;

    int      errorCount;
    int      checkCount;
    int      resolvedCount;
    pcT      expPc;
    pcT      expTarget;
    logic    expTaken;
    logic    expPred;
    // Decode register addresses seen one cycle before a resolve
    regAddrT lastRs1Addr;
    regAddrT lastRs2Addr;
    // Fetch address owed after a mispredict
    logic    redirectDue;
    pcT      redirectExp;

    `include "branchRefModel.svh"

    branchFrontEnd dut0 (
        .clk             (clk),
        .reset           (reset),
        .instrF          (instrF),
        .rs1Data         (rs1Data),
        .rs2Data         (rs2Data),
        .pcF             (pcF),
        .rs1Addr         (rs1Addr),
        .rs2Addr         (rs2Addr),
        .resolve         (resolve),
        .branchCount     (branchCount),
        .mispredictCount (mispredictCount)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Memory and register file answer the addresses set by the last edge
    always @(posedge clk) begin
        #1;
        instrF  = image[pcF[9:2]];
        rs1Data = regVal[rs1Addr];
        rs2Data = regVal[rs2Addr];
    end

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Each defined condition has to resolve both ways
    task automatic checkCoverage();
        funct3T codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int c = 0; c < 6; c++) begin
            if (!takenSeen[codes[c]] || !notTakenSeen[codes[c]]) begin
                errorCount++;
                $display("Condition funct3 %b was not resolved in both directions", codes[c]);
            end
        end
    endtask

    initial begin
        reset         = 1'b0;
        instrF        = '0;
        rs1Data       = '0;
        rs2Data       = '0;
        errorCount    = 0;
        checkCount    = 0;
        resolvedCount = 0;
        lastRs1Addr   = '0;
        lastRs2Addr   = '0;
        redirectDue   = 1'b0;
        redirectExp   = '0;
        buildImage();
        // State while reset is held
        repeat (3) @(posedge clk);
        @(negedge clk);
        compareValue("reset pcF", resetPc, pcF);
        compareValue("reset resolve.valid", 32'd0, resolve.valid);
        compareValue("reset branchCount", 32'd0, branchCount);
        compareValue("reset mispredictCount", 32'd0, mispredictCount);
        @(posedge clk);
        #1 reset = 1'b1;
        // Every valid resolve must be the next branch on the model path
        while (resolvedCount < numResolves) begin
            @(negedge clk);
            // Redirected fetch address lands on the edge after the mispredict
            if (redirectDue) begin
                compareValue("pcF after redirect", redirectExp, pcF);
                redirectDue = 1'b0;
            end
            if (resolve.valid !== 1'b0) begin
                walkToBranch(expPc, expTaken, expTarget, expPred);
                compareValue("resolve.pc", expPc, resolve.pc);
                compareValue("resolve.taken", expTaken, resolve.taken);
                compareValue("resolve.target", expTarget, resolve.target);
                compareValue("resolve.predTaken", expPred, resolve.predTaken);
                compareValue("resolve.mispredict", expTaken != expPred, resolve.mispredict);
                compareValue("rs1Addr", brRs1[expPc[9:2]], lastRs1Addr);
                compareValue("rs2Addr", brRs2[expPc[9:2]], lastRs2Addr);
                if (expTaken != expPred) begin
                    redirectDue = 1'b1;
                    redirectExp = expTarget;
                end
                resolvedCount++;
            end
            lastRs1Addr = rs1Addr;
            lastRs2Addr = rs2Addr;
        end
        // Counters step on the edge after the last resolve
        @(posedge clk);
        @(negedge clk);
        if (redirectDue) begin
            compareValue("pcF after redirect", redirectExp, pcF);
        end
        compareValue("branchCount", branchTally, branchCount);
        compareValue("mispredictCount", mispredictTally, mispredictCount);
        checkCoverage();
        $display("Closing: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(20 * plannedCycles * clkPeriod);
        $display("Timeout, only %0d of %0d branches resolved", resolvedCount, numResolves);
        $display("Closing: %0d checks, %0d errors", checkCount, errorCount);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+bench
design/branchPredPkg.sv
design/branchTargetBuffer.sv
design/fetchPc.sv
design/branchDecode.sv
design/branchExecute.sv
design/predictionStats.sv
design/branchFrontEnd.sv
bench/branchFrontEndTb.sv

// ==== Bender.yml ====
package:
  name: branch_front_end

sources:
  # Design sources, package first
  - target: any(rtl, test)
    files:
      - design/branchPredPkg.sv
      - design/branchTargetBuffer.sv
      - design/fetchPc.sv
      - design/branchDecode.sv
      - design/branchExecute.sv
      - design/predictionStats.sv
      - design/branchFrontEnd.sv

  # Testbench with its included reference model
  - target: test
    include_dirs:
      - bench
    files:
      - bench/branchFrontEndTb.sv
